/* scalar_pkg.sv */
// Shared definitions for the scalar unit
// Widths, opcodes, branch conditions, instruction and stage payloads

package scalar_pkg;

	localparam int DATA_W   = 32;
	localparam int NUM_REGS = 16;
	localparam int ADDR_W   = 10;
	localparam int IMM_W    = 16;

	typedef logic [DATA_W-1:0]           data_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [ADDR_W-1:0]           addr_t;

	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_sub  = 4'h1,
		op_and  = 4'h2,
		op_or   = 4'h3,
		op_xor  = 4'h4,
		op_sll  = 4'h5,
		op_addi = 4'h6,
		op_cmp  = 4'h7,
		op_movv = 4'h8,
		op_brc  = 4'h9,
		op_jmp  = 4'ha,
		op_halt = 4'hb,
		op_nop  = 4'hf
	} opcode_e;

	// Branch condition carried in the dst field
	typedef enum logic [3:0] {
		cond_zero    = 4'h0,
		cond_nonzero = 4'h1,
		cond_neg     = 4'h2,
		cond_carry   = 4'h3
	} cond_e;

	// Raw opcode bits with unknown codes decoded in issue
	typedef struct packed {
		logic [3:0]       opcode;
		reg_idx_t         dst;
		reg_idx_t         src1;
		reg_idx_t         src2;
		logic [IMM_W-1:0] imm;
	} instr_t;

	typedef struct packed {
		logic zero;
		logic neg;
		logic carry;
	} status_t;

	// Issue to execute
	typedef struct packed {
		opcode_e          opcode;
		reg_idx_t         dst;
		data_t            a;
		data_t            b;
		logic [IMM_W-1:0] imm;
		addr_t            pc;
	} exec_cmd_t;

	// Execute to write-back
	typedef struct packed {
		logic     reg_we;
		logic     vec;
		reg_idx_t dst;
		data_t    data;
	} wb_t;

endpackage

/* pipe_stage.sv */
// Pipeline register with valid, hold and flush
// Payload given by a type parameter

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     en,
	input  logic     flush,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (en) begin
			out_valid <= in_valid & ~flush;
		end
	end

	always_ff @(posedge clock) begin
		if (en) begin
			out_data <= in_data;
		end
	end

	assert property (@(posedge clock) $past(reset) |-> !out_valid);

endmodule

/* fetch_unit.sv */
// Fetch unit
// Program counter, instruction-memory read, branch redirect and stop at halt

module fetch_unit
	import scalar_pkg::*;
(
	input  logic  clock,
	input  logic  reset,
	input  logic  en,
	input  logic  redirect,
	input  addr_t target,
	input  logic  halt,
	output logic  imem_re,
	output addr_t imem_addr,
	output logic  issue_valid,
	output addr_t issue_pc
);

	addr_t pc;
	logic  started;
	logic  stopped;

	// Idle for one cycle out of reset and for good after a halt
	assign imem_re   = en & started & ~stopped & ~halt;
	assign imem_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= '0;
			started     <= 1'b0;
			stopped     <= 1'b0;
			issue_valid <= 1'b0;
		end else begin
			started <= 1'b1;
			if (halt) begin
				stopped <= 1'b1;
			end
			if (en) begin
				// Word fetched alongside a redirect is on the wrong path
				issue_valid <= imem_re & ~redirect;
				if (redirect) begin
					pc <= target;
				end else if (imem_re) begin
					pc <= pc + addr_t'(1);
				end
			end
		end
	end

	// Address of the word now returning from memory
	always_ff @(posedge clock) begin
		if (en && imem_re) begin
			issue_pc <= pc;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		stopped |-> !imem_re && !issue_valid);

endmodule

/* reg_file.sv */
// Register file
// Sixteen words, two combinational reads, one synchronous write

module reg_file
	import scalar_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  data_t    wr_data,
	input  reg_idx_t rd_idx_a,
	input  reg_idx_t rd_idx_b,
	output data_t    rd_data_a,
	output data_t    rd_data_b
);

	data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Same-cycle write is covered by forwarding in issue
	assign rd_data_a = regs[rd_idx_a];
	assign rd_data_b = regs[rd_idx_b];

endmodule

/* issue_stage.sv */
// Issue stage
// Opcode decode, operand read and forwarding from execute and write-back

module issue_stage
	import scalar_pkg::*;
(
	input  logic      in_valid,
	input  instr_t    instr,
	input  addr_t     pc,
	output reg_idx_t  rd_idx_a,
	output reg_idx_t  rd_idx_b,
	input  data_t     rd_data_a,
	input  data_t     rd_data_b,
	input  logic      ex_valid,
	input  wb_t       ex_result,
	input  logic      wb_valid,
	input  wb_t       wb_result,
	output logic      cmd_valid,
	output exec_cmd_t cmd
);

	opcode_e opcode;

	// Youngest producer first, then write-back, then the register file
	function automatic data_t forward(input reg_idx_t idx, input data_t rf_data);
		data_t value;
		if (ex_valid && ex_result.reg_we && ex_result.dst == idx) begin
			value = ex_result.data;
		end else if (wb_valid && wb_result.reg_we && wb_result.dst == idx) begin
			value = wb_result.data;
		end else begin
			value = rf_data;
		end
		return value;
	endfunction

	always_comb begin
		case (instr.opcode)
			op_add, op_sub, op_and, op_or, op_xor, op_sll, op_addi,
			op_cmp, op_movv, op_brc, op_jmp, op_halt: begin
				opcode = opcode_e'(instr.opcode);
			end
			default: begin
				opcode = op_nop;
			end
		endcase
	end

	assign rd_idx_a = instr.src1;
	assign rd_idx_b = instr.src2;

	// Nops have no effect and never enter execute
	assign cmd_valid = in_valid & (opcode != op_nop);

	always_comb begin
		cmd.opcode = opcode;
		cmd.dst    = instr.dst;
		cmd.a      = forward(instr.src1, rd_data_a);
		cmd.b      = forward(instr.src2, rd_data_b);
		cmd.imm    = instr.imm;
		cmd.pc     = pc;
	end

endmodule

/* exec_unit.sv */
// Execute unit
// ALU, status register, branch decision and halt detection

module exec_unit
	import scalar_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      en,
	input  logic      cmd_valid,
	input  exec_cmd_t cmd,
	output logic      result_valid,
	output wb_t       result,
	output logic      redirect,
	output addr_t     target,
	output logic      halt,
	output status_t   status
);

	logic  fire;
	data_t imm_ext;
	data_t alu_res;
	logic  alu_carry;
	logic  is_alu;
	logic  writes;
	logic  taken;

	assign fire    = cmd_valid & en;
	assign imm_ext = {{(DATA_W-IMM_W){cmd.imm[IMM_W-1]}}, cmd.imm};

	////////////////////////////////////////////////////////////////////////////
	// ALU

	always_comb begin
		alu_res   = '0;
		alu_carry = 1'b0;
		is_alu    = 1'b1;
		writes    = 1'b1;
		case (cmd.opcode)
			op_add:  {alu_carry, alu_res} = {1'b0, cmd.a} + {1'b0, cmd.b};
			op_sub:  {alu_carry, alu_res} = {1'b0, cmd.a} - {1'b0, cmd.b};
			op_addi: {alu_carry, alu_res} = {1'b0, cmd.a} + {1'b0, imm_ext};
			op_and:  alu_res = cmd.a & cmd.b;
			op_or:   alu_res = cmd.a | cmd.b;
			op_xor:  alu_res = cmd.a ^ cmd.b;
			op_sll:  alu_res = cmd.a << cmd.b[4:0];
			op_cmp: begin
				{alu_carry, alu_res} = {1'b0, cmd.a} - {1'b0, cmd.b};
				writes = 1'b0;
			end
			default: begin
				is_alu = 1'b0;
				writes = 1'b0;
			end
		endcase
	end

	// Status follows every enabled ALU operation
	always_ff @(posedge clock) begin
		if (reset) begin
			status <= '0;
		end else if (fire && is_alu) begin
			status.zero  <= (alu_res == '0);
			status.neg   <= alu_res[DATA_W-1];
			status.carry <= alu_carry;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Branch, jump and halt

	always_comb begin
		case (cond_e'(cmd.dst))
			cond_zero:    taken = status.zero;
			cond_nonzero: taken = ~status.zero;
			cond_neg:     taken = status.neg;
			cond_carry:   taken = status.carry;
			default:      taken = 1'b0;
		endcase
	end

	assign target   = (cmd.opcode == op_jmp) ? cmd.imm[ADDR_W-1:0] :
		cmd.pc + addr_t'(1) + imm_ext[ADDR_W-1:0];
	assign redirect = fire & ((cmd.opcode == op_jmp) | ((cmd.opcode == op_brc) & taken));
	assign halt     = fire & (cmd.opcode == op_halt);

	assign result_valid  = cmd_valid;
	assign result.reg_we = writes;
	assign result.vec    = (cmd.opcode == op_movv);
	assign result.dst    = cmd.dst;
	assign result.data   = (cmd.opcode == op_movv) ? cmd.a : alu_res;

	assert property (@(posedge clock) disable iff (reset) !(redirect && halt));

	// Younger instruction behind a redirect or halt never executes
	assert property (@(posedge clock) disable iff (reset)
		(redirect || halt) |=> !cmd_valid);

endmodule

/* scalar_unit.sv */
// Scalar unit top level
// Fetch, issue, execute and write-back stages around the register file

module scalar_unit
	import scalar_pkg::*;
(
	input  logic    clock,
	input  logic    reset,
	input  logic    en,
	output logic    imem_re,
	output addr_t   imem_addr,
	input  instr_t  imem_instr,
	output logic    vec_valid,
	output data_t   vec_data,
	output status_t status,
	output logic    term
);

	logic      issue_valid;
	addr_t     issue_pc;
	reg_idx_t  rd_idx_a;
	reg_idx_t  rd_idx_b;
	data_t     rd_data_a;
	data_t     rd_data_b;
	logic      cmd_valid_d;
	exec_cmd_t cmd_d;
	logic      cmd_valid_q;
	exec_cmd_t cmd_q;
	logic      ex_valid;
	wb_t       ex_result;
	logic      wb_valid;
	wb_t       wb_result;
	logic      redirect;
	addr_t     target;

	fetch_unit fetch (
		.clock       (clock),
		.reset       (reset),
		.en          (en),
		.redirect    (redirect),
		.target      (target),
		.halt        (term),
		.imem_re     (imem_re),
		.imem_addr   (imem_addr),
		.issue_valid (issue_valid),
		.issue_pc    (issue_pc)
	);

	issue_stage issue (
		.in_valid  (issue_valid),
		.instr     (imem_instr),
		.pc        (issue_pc),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex_valid  (ex_valid),
		.ex_result (ex_result),
		.wb_valid  (wb_valid),
		.wb_result (wb_result),
		.cmd_valid (cmd_valid_d),
		.cmd       (cmd_d)
	);

	pipe_stage #(.payload_t(exec_cmd_t)) exec_reg (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.flush     (redirect | term),
		.in_valid  (cmd_valid_d),
		.in_data   (cmd_d),
		.out_valid (cmd_valid_q),
		.out_data  (cmd_q)
	);

	exec_unit exec (
		.clock        (clock),
		.reset        (reset),
		.en           (en),
		.cmd_valid    (cmd_valid_q),
		.cmd          (cmd_q),
		.result_valid (ex_valid),
		.result       (ex_result),
		.redirect     (redirect),
		.target       (target),
		.halt         (term),
		.status       (status)
	);

	pipe_stage #(.payload_t(wb_t)) wb_reg (
		.clock     (clock),
		.reset     (reset),
		.en        (en),
		.flush     (1'b0),
		.in_valid  (ex_valid),
		.in_data   (ex_result),
		.out_valid (wb_valid),
		.out_data  (wb_result)
	);

	reg_file rf (
		.clock     (clock),
		.reset     (reset),
		.we        (wb_valid & wb_result.reg_we),
		.wr_idx    (wb_result.dst),
		.wr_data   (wb_result.data),
		.rd_idx_a  (rd_idx_a),
		.rd_idx_b  (rd_idx_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	// One word per enabled write-back cycle
	assign vec_valid = en & wb_valid & wb_result.vec;
	assign vec_data  = wb_result.data;

endmodule

/* tb_model.svh */
// Random program generator and instruction-set reference model
// LCG, program builder and in-order interpreter for the testbench

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	logic [31:0] rand_state = 32'd9;
	instr_t      prog [PROG_LEN];
	data_t       exp_vec [$];
	status_t     exp_status;

	function automatic int next_random();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return int'(rand_state[31:16]);
	endfunction

	function automatic logic cond_met(input reg_idx_t cond, input status_t st);
		logic met;
		case (cond)
			cond_zero:    met = st.zero;
			cond_nonzero: met = !st.zero;
			cond_neg:     met = st.neg;
			cond_carry:   met = st.carry;
			default:      met = 1'b0;
		endcase
		return met;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Program builder

	// Seeded registers first, then a weighted body, halt last
	task automatic make_program();
		int pick;
		int offset;
		for (int i = 0; i < PROG_LEN; i++) begin
			pick   = next_random() % 32;
			offset = 1 + next_random() % 4;
			// Forward targets never pass the final halt
			if (i + 1 + offset > PROG_LEN - 1) begin
				offset = PROG_LEN - 2 - i;
			end
			prog[i].opcode = 4'(pick % 8);
			prog[i].dst    = reg_idx_t'(next_random() % 8);
			prog[i].src1   = reg_idx_t'(next_random() % 8);
			prog[i].src2   = reg_idx_t'(next_random() % 8);
			prog[i].imm    = 16'(next_random());
			if (i < 8) begin
				prog[i].opcode = op_addi;
				prog[i].dst    = reg_idx_t'(i);
			end else if (i == PROG_LEN - 1) begin
				prog[i].opcode = op_halt;
			end else if (pick >= 16 && pick < 23) begin
				prog[i].opcode = op_movv;
			end else if (pick >= 23 && pick < 27) begin
				prog[i].opcode = op_brc;
				prog[i].dst    = reg_idx_t'(next_random() % 4);
				prog[i].imm    = 16'(offset);
			end else if (pick >= 27 && pick < 29) begin
				prog[i].opcode = op_jmp;
				prog[i].imm    = 16'(i + 1 + offset);
			end else if (pick >= 29) begin
				// Unused codes behave as nop
				prog[i].opcode = 4'(12 + pick % 4);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	task automatic run_model();
		data_t   regs [NUM_REGS];
		instr_t  ins;
		status_t st;
		data_t   a;
		data_t   b;
		data_t   imm_ext;
		data_t   res;
		logic    carry;
		logic    is_alu;
		logic    done;
		int      pc;
		exp_vec.delete();
		for (int r = 0; r < NUM_REGS; r++) begin
			regs[r] = '0;
		end
		st   = '0;
		pc   = 0;
		done = 1'b0;
		while (!done) begin
			ins     = prog[pc];
			a       = regs[ins.src1];
			b       = regs[ins.src2];
			imm_ext = {{16{ins.imm[15]}}, ins.imm};
			res     = '0;
			carry   = 1'b0;
			is_alu  = 1'b1;
			pc      = pc + 1;
			case (ins.opcode)
				op_add: begin
					res   = a + b;
					carry = res < a;
				end
				op_addi: begin
					res   = a + imm_ext;
					carry = res < a;
				end
				op_sub, op_cmp: begin
					res   = a - b;
					carry = a < b;
				end
				op_and:  res = a & b;
				op_or:   res = a | b;
				op_xor:  res = a ^ b;
				op_sll:  res = a << b[4:0];
				op_movv: begin
					is_alu = 1'b0;
					exp_vec.push_back(a);
				end
				op_brc: begin
					is_alu = 1'b0;
					if (cond_met(ins.dst, st)) begin
						pc = pc + int'(imm_ext);
					end
				end
				op_jmp: begin
					is_alu = 1'b0;
					pc     = int'(ins.imm[ADDR_W-1:0]);
				end
				op_halt: begin
					is_alu = 1'b0;
					done   = 1'b1;
				end
				default: is_alu = 1'b0;
			endcase
			if (is_alu) begin
				st.zero  = (res == '0);
				st.neg   = res[DATA_W-1];
				st.carry = carry;
				if (ins.opcode != op_cmp) begin
					regs[ins.dst] = res;
				end
			end
		end
		exp_status = st;
	endtask

`endif

/* tb_scalar_unit.sv */
// Testbench for the scalar unit
// Clock, instruction memory, random programs, enable pattern and result checks

module tb_scalar_unit
	import scalar_pkg::*;
();

	localparam int PROG_LEN     = 48;
	localparam int NUM_PROGS    = 20;
	localparam int RESET_CYCLES = 16;
	localparam int TAIL_CYCLES  = 8;
	localparam int MAX_CYCLES   = NUM_PROGS * (RESET_CYCLES + PROG_LEN * 8);

	logic    clock = 1'b0;
	logic    reset = 1'b1;
	logic    en = 1'b0;
	instr_t  imem_instr = '0;
	logic    imem_re;
	addr_t   imem_addr;
	logic    vec_valid;
	data_t   vec_data;
	status_t status;
	logic    term;

	instr_t imem [2**ADDR_W];
	int     cycles = 0;

	`include "tb_model.svh"

	scalar_unit dut0 (
		.clock      (clock),
		.reset      (reset),
		.en         (en),
		.imem_re    (imem_re),
		.imem_addr  (imem_addr),
		.imem_instr (imem_instr),
		.vec_valid  (vec_valid),
		.vec_data   (vec_data),
		.status     (status),
		.term       (term)
	);

	initial begin
		forever begin
			#50 clock = ~clock;
		end
	end

	// Instruction memory with one cycle of read latency
	always @(posedge clock) begin
		if (imem_re) begin
			imem_instr <= imem[imem_addr];
		end
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			stop_with_failure();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input data_t actual, input data_t expected);
		if (actual !== expected) begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_status(input string name, input status_t actual,
		input status_t expected);
		if (actual !== expected) begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("error %s: got %h, expected %h", name, actual, expected);
			stop_with_failure();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	// High about three cycles in four
	function automatic logic pick_enable();
		return (next_random() % 4) != 0;
	endfunction

	// Fill words are nops tagged with their own address
	task automatic load_memory();
		for (int addr = 0; addr < 2**ADDR_W; addr++) begin
			imem[addr] = {4'hf, 28'(addr)};
		end
		for (int i = 0; i < PROG_LEN; i++) begin
			imem[i] = prog[i];
		end
	endtask

	task automatic run_program();
		int   vec_count;
		int   tail;
		logic halted;
		logic fetched;
		vec_count = 0;
		tail      = 0;
		halted    = 1'b0;
		fetched   = 1'b0;
		for (int c = 0; c < RESET_CYCLES; c++) begin
			@(posedge clock);
			reset <= 1'b1;
			en    <= pick_enable();
		end
		@(posedge clock);
		reset <= 1'b0;
		en    <= pick_enable();
		@(negedge clock);
		check_bit("imem_re", imem_re, 1'b0);
		check_bit("vec_valid", vec_valid, 1'b0);
		check_bit("term", term, 1'b0);
		check_status("status", status, '0);
		while (tail < TAIL_CYCLES) begin
			@(posedge clock);
			en <= pick_enable();
			@(negedge clock);
			if (!en) begin
				check_bit("imem_re", imem_re, 1'b0);
				check_bit("vec_valid", vec_valid, 1'b0);
			end
			// Nothing moves once halted
			if (halted) begin
				check_bit("term", term, 1'b0);
				check_bit("imem_re", imem_re, 1'b0);
				check_bit("vec_valid", vec_valid, 1'b0);
				tail++;
			end
			if (imem_re && !fetched) begin
				check_data("imem_addr", data_t'(imem_addr), '0);
				fetched = 1'b1;
			end
			if (vec_valid) begin
				if (vec_count >= exp_vec.size()) begin
					$display("More words on vec_data than the model expects");
					stop_with_failure();
				end else begin
					check_data("vec_data", vec_data, exp_vec[vec_count]);
					vec_count++;
				end
			end
			if (term) begin
				check_status("status", status, exp_status);
				halted = 1'b1;
			end
		end
		if (vec_count != exp_vec.size()) begin
			$display("Only %0d words on vec_data where the model expects %0d",
				vec_count, exp_vec.size());
			stop_with_failure();
		end
	endtask

	initial begin
		for (int p = 0; p < NUM_PROGS; p++) begin
			make_program();
			run_model();
			load_memory();
			run_program();
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* list.f */
+incdir+.
scalar_pkg.sv
pipe_stage.sv
fetch_unit.sv
reg_file.sv
issue_stage.sv
exec_unit.sv
scalar_unit.sv
tb_scalar_unit.sv

/* Makefile */
SOURCES := $(filter %.sv,$(shell cat list.f))

.PHONY: run clean

run: obj_dir/Vtb_scalar_unit
	@./obj_dir/Vtb_scalar_unit > sim.log 2>&1; rc=$$?; cat sim.log; \
		if [ $$rc -ne 0 ] || grep -q "Result: FAILED" sim.log; then exit 1; fi

obj_dir/Vtb_scalar_unit: list.f $(SOURCES) tb_model.svh
	verilator --binary --timing --assert -f list.f --top-module tb_scalar_unit

clean:
	rm -rf obj_dir sim.log
